// ==== design/fetch_pkg.sv ====
package fetch_pkg;

	// data and address width
	localparam int xlen = 32;

	// instruction queue sizing, 16 entries
	localparam int queue_depth_log2 = 4;
	// leaves room for the one read that may still be in flight
	localparam int queue_almost_full_level = 14;

	// opcodes seen by the static predictor
	localparam logic [6:0] opcode_branch = 7'b1100011;
	localparam logic [6:0] opcode_jal = 7'b1101111;

	// fixed instruction words
	localparam logic [xlen-1:0] instr_ecall = 32'h0000_0073;
	localparam logic [xlen-1:0] instr_nop = 32'h0000_0013;

	// configuration register map
	localparam logic cfg_addr_boot_pc = 1'b0;
	localparam logic cfg_addr_endian = 1'b1;

	// fetch FSM encoding
	localparam logic [1:0] st_halt = 2'd0;
	localparam logic [1:0] st_fetch = 2'd1;
	localparam logic [1:0] st_stall = 2'd2;
	localparam logic [1:0] st_ecall_wait = 2'd3;

	// AXI-Lite read master encoding
	localparam logic [1:0] axr_idle = 2'd0;
	localparam logic [1:0] axr_addr = 2'd1;
	localparam logic [1:0] axr_data = 2'd2;

	// unprivileged, secure, instruction access
	localparam logic [2:0] arprot_instr = 3'b100;

	// B-type field split, msb first
	typedef struct packed {
		logic		imm_12;
		logic [5:0]	imm_10_5;
		logic [4:0]	rs2;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [3:0]	imm_4_1;
		logic		imm_11;
		logic [6:0]	opcode;
	} b_fields_t;

	// one instruction word, raw or as branch fields
	typedef union packed {
		logic [xlen-1:0]	raw;
		b_fields_t		b_fields;
	} instr_u;

endpackage

// ==== design/fetch_cfg_regs.sv ====
`timescale 1ns/1ns

module fetch_cfg_regs (
	input	logic				clk,
	input	logic				rst_n,

	// plain write strobe
	input	logic				cfg_wr,
	input	logic				cfg_addr,
	input	logic [fetch_pkg::xlen-1:0]	cfg_wdata,

	// to the fetch unit
	output	logic [fetch_pkg::xlen-1:0]	boot_pc,
	output	logic				big_endian
);

	import fetch_pkg::*;

	logic sel_boot_pc;
	logic sel_endian;

	// register select
	assign sel_boot_pc = cfg_wr && (cfg_addr == cfg_addr_boot_pc);
	assign sel_endian = cfg_wr && (cfg_addr == cfg_addr_endian);

	// boot address, kept word aligned
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			boot_pc <= '0;
		end else if (sel_boot_pc) begin
			boot_pc <= {cfg_wdata[xlen-1:2], 2'b00};
		end
	end

	// byte-order flag, little endian after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			big_endian <= 1'b0;
		end else if (sel_endian) begin
			big_endian <= cfg_wdata[0];
		end
	end

endmodule

// ==== design/axil_instr_reader.sv ====
`timescale 1ns/1ns

module axil_instr_reader (
	input	logic				clk,
	input	logic				rst_n,

	// request side from the fetch unit
	input	logic				rd_req,
	input	logic [fetch_pkg::xlen-1:0]	rd_addr,
	output	logic				done,
	output	logic [fetch_pkg::xlen-1:0]	rd_data,

	// AXI-Lite read address channel
	output	logic [fetch_pkg::xlen-1:0]	araddr,
	output	logic [2:0]			arprot,
	output	logic				arvalid,
	input	logic				arready,

	// AXI-Lite read data channel
	input	logic [fetch_pkg::xlen-1:0]	rdata,
	input	logic [1:0]			rresp,
	input	logic				rvalid,
	output	logic				rready
);

	import fetch_pkg::*;

	logic [1:0] state;
	logic [1:0] state_nxt;
	logic [xlen-1:0] addr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= axr_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// request address, captured once per read
	always_ff @(posedge clk) begin
		if (state == axr_idle && rd_req) begin
			addr_q <= rd_addr;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			axr_idle: begin
				if (rd_req) begin
					state_nxt = axr_addr;
				end
			end
			axr_addr: begin
				if (arready) begin
					state_nxt = axr_data;
				end
			end
			axr_data: begin
				if (rvalid) begin
					state_nxt = axr_idle;
				end
			end
			default: begin
				state_nxt = axr_idle;
			end
		endcase
	end

	assign araddr = addr_q;
	assign arprot = arprot_instr;
	assign arvalid = (state == axr_addr);
	assign rready = (state == axr_data);

	// rresp is not checked, bus errors are out of scope
	assign done = rvalid && rready;
	assign rd_data = rdata;

endmodule

// ==== design/instr_queue.sv ====
`timescale 1ns/1ns

module instr_queue (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				flush,

	// write side
	input	logic				wr_en,
	input	logic [fetch_pkg::xlen-1:0]	wr_instr,
	input	logic [fetch_pkg::xlen-1:0]	wr_pc,
	input	logic				wr_taken,

	// read side, head shown combinationally
	input	logic				rd_en,
	output	logic [fetch_pkg::xlen-1:0]	head_instr,
	output	logic [fetch_pkg::xlen-1:0]	head_pc,
	output	logic				head_taken,

	output	logic				empty,
	output	logic				almost_full
);

	import fetch_pkg::*;

	// entry is {instr, pc, taken}
	logic [2*xlen:0] mem [2**queue_depth_log2];
	logic [queue_depth_log2-1:0] wr_ptr;
	logic [queue_depth_log2-1:0] rd_ptr;
	logic [queue_depth_log2:0] count;
	logic do_rd;

	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= {wr_instr, wr_pc, wr_taken};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// count only moves when exactly one side is active
			if (wr_en && !do_rd) begin
				count <= count + 1'b1;
			end else if (!wr_en && do_rd) begin
				count <= count - 1'b1;
			end
		end
	end

	assign {head_instr, head_pc, head_taken} = mem[rd_ptr];
	assign empty = (count == '0);
	assign almost_full = (count >= queue_almost_full_level);

endmodule

// ==== design/branch_predict.sv ====
`timescale 1ns/1ns

module branch_predict (
	input	fetch_pkg::instr_u		instr,
	input	logic [fetch_pkg::xlen-1:0]	pc,
	output	logic				taken,
	output	logic [fetch_pkg::xlen-1:0]	target
);

	import fetch_pkg::*;

	logic is_branch;
	logic is_jal;
	logic [xlen-1:0] b_imm;
	logic [xlen-1:0] j_imm;

	assign is_branch = (instr.b_fields.opcode == opcode_branch);
	assign is_jal = (instr.b_fields.opcode == opcode_jal);

	// B immediate from the branch field view
	assign b_imm = {
		{(xlen-12){instr.b_fields.imm_12}},
		instr.b_fields.imm_11,
		instr.b_fields.imm_10_5,
		instr.b_fields.imm_4_1,
		1'b0
	};

	// J immediate straight from the raw word
	assign j_imm = {
		{(xlen-20){instr.raw[31]}},
		instr.raw[19:12],
		instr.raw[20],
		instr.raw[30:21],
		1'b0
	};

	// backward taken, forward not taken, JAL always
	assign taken = is_jal || (is_branch && instr.b_fields.imm_12);
	assign target = pc + (is_jal ? j_imm : b_imm);

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
	input	logic				clk,
	input	logic				rst_n,

	// decode-stage control
	input	logic				go,
	input	logic				stall,
	input	logic				flush,
	input	logic [fetch_pkg::xlen-1:0]	pc_bj,
	input	logic				ecall_retire,

	// configuration
	input	logic [fetch_pkg::xlen-1:0]	boot_pc,
	input	logic				big_endian,

	// bus reader
	output	logic				rd_req,
	output	logic [fetch_pkg::xlen-1:0]	rd_addr,
	input	logic				done,
	input	logic [fetch_pkg::xlen-1:0]	rd_data,

	// to decode
	output	fetch_pkg::instr_u		instr,
	output	logic [fetch_pkg::xlen-1:0]	pc_out,
	output	logic [fetch_pkg::xlen-1:0]	pc_p4_out,
	output	logic				taken,
	output	logic				instr_valid
);

	import fetch_pkg::*;

	logic [1:0] state;
	logic [1:0] state_nxt;
	logic [xlen-1:0] pc;
	logic pending;
	logic drop;
	logic accept;
	logic is_ecall;
	instr_u fetched;
	logic pred_taken;
	logic [xlen-1:0] pred_target;
	logic [xlen-1:0] head_instr;
	logic [xlen-1:0] head_pc;
	logic head_taken;
	logic q_empty;
	logic q_almost_full;
	logic q_rd;

	// byte-order normalization
	assign fetched.raw = big_endian ?
		{rd_data[7:0], rd_data[15:8], rd_data[23:16], rd_data[31:24]} : rd_data;

	// a done is kept unless a flush caught it
	assign accept = done && !drop && !flush;
	assign is_ecall = (fetched.raw == instr_ecall);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_halt;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_halt: begin
				if (go) begin
					state_nxt = st_fetch;
				end
			end
			st_fetch, st_stall: begin
				// in-flight read still lands while stalled
				if (accept && is_ecall) begin
					state_nxt = st_ecall_wait;
				end else if (q_almost_full) begin
					state_nxt = st_stall;
				end else begin
					state_nxt = st_fetch;
				end
			end
			st_ecall_wait: begin
				if (ecall_retire) begin
					state_nxt = st_halt;
				end
			end
			default: begin
				state_nxt = st_halt;
			end
		endcase
	end

	// one read at a time, none in a flush cycle
	assign rd_req = (state == st_fetch) && !pending && !q_almost_full && !flush;
	assign rd_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			drop <= 1'b0;
		end else begin
			if (rd_req) begin
				pending <= 1'b1;
			end else if (done) begin
				pending <= 1'b0;
			end
			if (done) begin
				drop <= 1'b0;
			end else if (flush && pending) begin
				drop <= 1'b1;
			end
		end
	end

	// pc steering
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (flush) begin
			pc <= pc_bj;
		end else if (state == st_halt && go) begin
			pc <= boot_pc;
		end else if (accept) begin
			pc <= pred_taken ? pred_target : pc + 32'd4;
		end
	end

	branch_predict branch_predict_i (
		.instr		(fetched),
		.pc		(pc),
		.taken		(pred_taken),
		.target		(pred_target)
	);

	assign q_rd = instr_valid && !stall;

	instr_queue instr_queue_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.flush		(flush),
		.wr_en		(accept),
		.wr_instr	(fetched.raw),
		.wr_pc		(pc),
		.wr_taken	(pred_taken),
		.rd_en		(q_rd),
		.head_instr	(head_instr),
		.head_pc	(head_pc),
		.head_taken	(head_taken),
		.empty		(q_empty),
		.almost_full	(q_almost_full)
	);

	// decode side, NOP when the queue is empty
	assign instr_valid = !q_empty;
	assign instr.raw = instr_valid ? head_instr : instr_nop;
	assign pc_out = head_pc;
	assign pc_p4_out = head_pc + 32'd4;
	assign taken = instr_valid && head_taken;

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
	input	logic				clk,
	input	logic				rst_n,

	// configuration writes
	input	logic				cfg_wr,
	input	logic				cfg_addr,
	input	logic [fetch_pkg::xlen-1:0]	cfg_wdata,

	// decode-stage control
	input	logic				go,
	input	logic				stall,
	input	logic				flush,
	input	logic [fetch_pkg::xlen-1:0]	pc_bj,
	input	logic				ecall_retire,

	// decode-stage outputs
	output	fetch_pkg::instr_u		instr,
	output	logic [fetch_pkg::xlen-1:0]	pc_out,
	output	logic [fetch_pkg::xlen-1:0]	pc_p4_out,
	output	logic				taken,
	output	logic				instr_valid,

	// AXI-Lite read channel
	output	logic [fetch_pkg::xlen-1:0]	araddr,
	output	logic [2:0]			arprot,
	output	logic				arvalid,
	input	logic				arready,
	input	logic [fetch_pkg::xlen-1:0]	rdata,
	input	logic [1:0]			rresp,
	input	logic				rvalid,
	output	logic				rready
);

	import fetch_pkg::*;

	logic [xlen-1:0] boot_pc;
	logic big_endian;
	logic rd_req;
	logic [xlen-1:0] rd_addr;
	logic done;
	logic [xlen-1:0] rd_data;

	fetch_cfg_regs fetch_cfg_regs_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.cfg_wr		(cfg_wr),
		.cfg_addr	(cfg_addr),
		.cfg_wdata	(cfg_wdata),
		.boot_pc	(boot_pc),
		.big_endian	(big_endian)
	);

	fetch_unit fetch_unit_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.go		(go),
		.stall		(stall),
		.flush		(flush),
		.pc_bj		(pc_bj),
		.ecall_retire	(ecall_retire),
		.boot_pc	(boot_pc),
		.big_endian	(big_endian),
		.rd_req		(rd_req),
		.rd_addr	(rd_addr),
		.done		(done),
		.rd_data	(rd_data),
		.instr		(instr),
		.pc_out		(pc_out),
		.pc_p4_out	(pc_p4_out),
		.taken		(taken),
		.instr_valid	(instr_valid)
	);

	axil_instr_reader axil_instr_reader_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.rd_req		(rd_req),
		.rd_addr	(rd_addr),
		.done		(done),
		.rd_data	(rd_data),
		.araddr		(araddr),
		.arprot		(arprot),
		.arvalid	(arvalid),
		.arready	(arready),
		.rdata		(rdata),
		.rresp		(rresp),
		.rvalid		(rvalid),
		.rready		(rready)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output	logic	clk
);

	// 4 ns period
	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

endmodule

// ==== tests/axil_mem_model.sv ====
`timescale 1ns/1ns

module axil_mem_model (
	input	logic		clk,
	input	logic		rst_n,

	// read address channel
	input	logic [31:0]	araddr,
	input	logic		arvalid,
	output	logic		arready,

	// read data channel
	output	logic [31:0]	rdata,
	output	logic [1:0]	rresp,
	output	logic		rvalid,
	input	logic		rready
);

	// word array, loaded by the testbench
	logic [31:0] mem [256];

	int ar_wait;
	int r_wait;
	logic in_data;
	logic [7:0] idx;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= 2'b00;
			ar_wait <= 0;
			r_wait <= 0;
			in_data <= 1'b0;
			idx <= '0;
		end else if (!in_data) begin
			if (arvalid && arready) begin
				// address accepted, pick the data delay
				arready <= 1'b0;
				idx <= araddr[9:2];
				r_wait <= $urandom_range(3);
				in_data <= 1'b1;
			end else if (arvalid) begin
				if (ar_wait == 0) begin
					arready <= 1'b1;
				end else begin
					ar_wait <= ar_wait - 1;
				end
			end else begin
				ar_wait <= $urandom_range(3);
			end
		end else begin
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				in_data <= 1'b0;
				ar_wait <= $urandom_range(3);
			end else if (!rvalid) begin
				if (r_wait == 0) begin
					rvalid <= 1'b1;
					rdata <= mem[idx];
				end else begin
					r_wait <= r_wait - 1;
				end
			end
		end
	end

endmodule

// ==== tests/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

	import fetch_pkg::*;

	logic clk;
	logic rst_n;
	logic cfg_wr;
	logic cfg_addr;
	logic [31:0] cfg_wdata;
	logic go;
	logic stall;
	logic flush;
	logic [31:0] pc_bj;
	logic ecall_retire;
	instr_u instr;
	logic [31:0] pc_out;
	logic [31:0] pc_p4_out;
	logic taken;
	logic instr_valid;
	logic [31:0] araddr;
	logic [2:0] arprot;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// reference model state
	logic [31:0] image [256];
	logic [31:0] ref_pc;
	logic [31:0] ref_boot;
	logic ref_big;
	logic idle_expected;
	logic [31:0] exp_instr;
	logic exp_taken;
	logic take;
	logic stall_rand;
	logic flushed;
	int delivered;
	int taken_seen;

	tb_clock clock_i (
		.clk	(clk)
	);

	fetch_top fetch_top_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.cfg_wr		(cfg_wr),
		.cfg_addr	(cfg_addr),
		.cfg_wdata	(cfg_wdata),
		.go		(go),
		.stall		(stall),
		.flush		(flush),
		.pc_bj		(pc_bj),
		.ecall_retire	(ecall_retire),
		.instr		(instr),
		.pc_out		(pc_out),
		.pc_p4_out	(pc_p4_out),
		.taken		(taken),
		.instr_valid	(instr_valid),
		.araddr		(araddr),
		.arprot		(arprot),
		.arvalid	(arvalid),
		.arready	(arready),
		.rdata		(rdata),
		.rresp		(rresp),
		.rvalid		(rvalid),
		.rready		(rready)
	);

	axil_mem_model mem_model_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.araddr		(araddr),
		.arvalid	(arvalid),
		.arready	(arready),
		.rdata		(rdata),
		.rresp		(rresp),
		.rvalid		(rvalid),
		.rready		(rready)
	);

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// ADDI x1, x0, addr
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[11:0], 5'd0, 3'b000, 5'd1, 7'h13};
	endfunction

	function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
		return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
	endfunction

	function automatic logic predict_taken(input logic [31:0] w);
		return (w[6:0] == 7'h6f) || (w[6:0] == 7'h63 && w[31]);
	endfunction

	// next pc along the statically predicted path
	function automatic logic [31:0] next_pc(input logic [31:0] w, input logic [31:0] pc);
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		if (w[6:0] == 7'h6f) begin
			return pc + imm_j;
		end else if (w[6:0] == 7'h63 && w[31]) begin
			return pc + imm_b;
		end
		return pc + 32'd4;
	endfunction

	task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		$display("Test failures found");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic fail_text(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic put_word(input logic [31:0] addr, input logic [31:0] w);
		image[addr[9:2]] = w;
	endtask

	task automatic load_program();
		int a;
		for (a = 0; a < 1024; a += 4) begin
			put_word(a, fill_word(a));
		end
		// little-endian program from 0x40
		put_word(32'h60, enc_branch(3'b000, 13'd12));
		put_word(32'h68, enc_jal(21'h18));
		put_word(32'h84, enc_branch(3'b001, -13'sd16));
		put_word(32'h78, enc_jal(21'h28));
		put_word(32'hc0, 32'h0000_0073);
		// big-endian program from 0x100 stored byte swapped
		for (a = 32'h100; a < 32'h220; a += 4) begin
			put_word(a, swap_bytes(fill_word(a)));
		end
		put_word(32'h204, swap_bytes(enc_jal(21'h10)));
		put_word(32'h218, swap_bytes(32'h0000_0073));
		for (a = 0; a < 256; a++) begin
			mem_model_i.mem[a] = image[a];
		end
	endtask

	task automatic write_cfg(input logic addr, input logic [31:0] data);
		@(posedge clk);
		cfg_wr <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_wr <= 1'b0;
	endtask

	task automatic pulse_go();
		@(posedge clk);
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
		@(posedge clk);
	endtask

	task automatic wait_ecall_delivered();
		int n;
		n = 0;
		while (!idle_expected && n < 4000) begin
			@(posedge clk);
			n++;
		end
		if (!idle_expected) begin
			fail_text("the ECALL was never delivered");
		end
	endtask

	task automatic wait_deliveries(input int target);
		int n;
		n = 0;
		while (delivered < target && n < 2000) begin
			@(posedge clk);
			n++;
		end
		if (delivered < target) begin
			fail_text("instructions stopped arriving");
		end
	endtask

	// flush while an address phase is open
	task automatic flush_during_read(input logic [31:0] target);
		int n;
		n = 0;
		while (!arvalid && n < 500) begin
			@(posedge clk);
			n++;
		end
		if (!arvalid) begin
			fail_text("no read in flight to flush against");
		end else begin
			flush <= 1'b1;
			pc_bj <= target;
			@(posedge clk);
			flush <= 1'b0;
			// read still open on the bus during the flush cycle
			flushed = arvalid || rready;
		end
	endtask

	task automatic retire_ecall();
		repeat (12) @(posedge clk);
		ecall_retire <= 1'b1;
		@(posedge clk);
		ecall_retire <= 1'b0;
		// stays halted without a go
		repeat (20) @(posedge clk);
	endtask

	assign exp_instr = ref_big ? swap_bytes(image[ref_pc[9:2]]) : image[ref_pc[9:2]];
	assign exp_taken = predict_taken(exp_instr);
	assign take = instr_valid && !stall;

	always @(posedge clk) begin
		if (stall_rand) begin
			stall <= ($urandom_range(3) == 0);
		end else begin
			stall <= 1'b0;
		end
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_pc <= '0;
			idle_expected <= 1'b1;
			delivered <= 0;
			taken_seen <= 0;
		end else if (go) begin
			ref_pc <= ref_boot;
			idle_expected <= 1'b0;
		end else begin
			if (flush) begin
				ref_pc <= pc_bj;
			end else if (take) begin
				ref_pc <= next_pc(exp_instr, ref_pc);
			end
			if (take) begin
				delivered <= delivered + 1;
				if (taken) begin
					taken_seen <= taken_seen + 1;
				end
				if (exp_instr == 32'h0000_0073) begin
					idle_expected <= 1'b1;
				end
			end
		end
	end

	pc_check: assert property (@(posedge clk) disable iff (!rst_n) take |-> pc_out == ref_pc)
		else fail_value("pc_out", $sampled(pc_out), $sampled(ref_pc));

	instr_check: assert property (@(posedge clk) disable iff (!rst_n) take |-> instr == exp_instr)
		else fail_value("instr", $sampled(instr), $sampled(exp_instr));

	p4_check: assert property (@(posedge clk) disable iff (!rst_n)
		take |-> pc_p4_out == ref_pc + 32'd4)
		else fail_value("pc_p4_out", $sampled(pc_p4_out), $sampled(ref_pc) + 32'd4);

	taken_check: assert property (@(posedge clk) disable iff (!rst_n) take |-> taken == exp_taken)
		else fail_value("taken", $sampled(taken), $sampled(exp_taken));

	nop_check: assert property (@(posedge clk) disable iff (!rst_n)
		!instr_valid |-> instr == 32'h0000_0013)
		else fail_value("instr", $sampled(instr), 32'h0000_0013);

	idle_valid_check: assert property (@(posedge clk) disable iff (!rst_n)
		idle_expected |-> !instr_valid)
		else fail_value("instr_valid", $sampled(instr_valid), 32'd0);

	idle_bus_check: assert property (@(posedge clk) disable iff (!rst_n)
		idle_expected |-> !arvalid)
		else fail_value("arvalid", $sampled(arvalid), 32'd0);

	// instruction access, secure, unprivileged
	arprot_check: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid |-> arprot == 3'b100)
		else fail_value("arprot", $sampled(arprot), 32'd4);

	initial begin
		void'($urandom(32'h843a));
		rst_n <= 1'b0;
		cfg_wr <= 1'b0;
		cfg_addr <= 1'b0;
		cfg_wdata <= '0;
		go <= 1'b0;
		stall <= 1'b0;
		flush <= 1'b0;
		pc_bj <= '0;
		ecall_retire <= 1'b0;
		stall_rand = 1'b0;
		flushed = 1'b0;
		ref_big = 1'b0;
		ref_boot = '0;
		load_program();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		// idle before any go
		repeat (10) @(posedge clk);
		stall_rand <= 1'b1;

		// little endian run with branches ending in an ECALL
		write_cfg(cfg_addr_boot_pc, 32'h40);
		ref_boot = 32'h40;
		pulse_go();
		wait_ecall_delivered();
		retire_ecall();

		// big endian run flushed to 0x200 mid read
		write_cfg(cfg_addr_endian, 32'd1);
		ref_big = 1'b1;
		write_cfg(cfg_addr_boot_pc, 32'h100);
		ref_boot = 32'h100;
		pulse_go();
		wait_deliveries(delivered + 4);
		flush_during_read(32'h200);
		wait_ecall_delivered();
		retire_ecall();

		if (taken_seen < 4 || !flushed) begin
			fail_text("stimulus missed the taken or flush cases");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

// ==== files.f ====
design/fetch_pkg.sv
design/fetch_cfg_regs.sv
design/axil_instr_reader.sv
design/instr_queue.sv
design/branch_predict.sv
design/fetch_unit.sv
design/fetch_top.sv
tests/tb_clock.sv
tests/axil_mem_model.sv
tests/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - files:
      - design/fetch_pkg.sv
      - design/fetch_cfg_regs.sv
      - design/axil_instr_reader.sv
      - design/instr_queue.sv
      - design/branch_predict.sv
      - design/fetch_unit.sv
      - design/fetch_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/axil_mem_model.sv
      - tests/fetch_tb.sv
